//--- flist.f
hdl/rs_pkg.sv
hdl/rs_issue_if.sv
hdl/rs_reg_trk.sv
hdl/rs_entry.sv
hdl/rs_pick.sv
hdl/prf_file.sv
hdl/exec_alu.sv
hdl/rs_sched_top.sv
dv/tb_clk_gen.sv
dv/rs_sched_assert.sv
dv/rs_sched_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the issue cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f flist.f \
   --top-module rs_sched_tb \
   -Mdir obj_dir \
   -o rs_sched_sim

out=$(./obj_dir/rs_sched_sim)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
   exit 0
else
   exit 1
fi

//--- dv/rs_sched_tb.sv
`timescale 1ns/1ps

module rs_sched_tb import rs_pkg::*; ();

   localparam int RS_DEPTH     = 4;
   localparam int TOTAL_CYCLES = 450;  // Rough sum over all six tests

   logic         clk;
   logic         reset;
   logic         alloc;
   t_alu_op      alloc_op;
   t_prf_id      alloc_psrc1;
   logic         alloc_psrc1_pend;
   t_prf_id      alloc_psrc2;
   logic         alloc_psrc2_pend;
   t_prf_id      alloc_pdst;
   t_rob_id      alloc_rob_id;
   logic         ext_wr_en;
   t_prf_id      ext_wr_pdst;
   t_rv_reg_data ext_wr_data;
   logic         rs_full;
   logic         cmpl_valid;
   t_rob_id      cmpl_rob_id;
   t_prf_id      cmpl_pdst;
   t_rv_reg_data cmpl_data;

   // Model PRF holds the final value of every register, written once each
   t_rv_reg_data model_val [PRF_ENTRIES];
   bit           written   [PRF_ENTRIES];
   t_rv_reg_data exp_data  [32];
   t_prf_id      exp_pdst  [32];
   bit           exp_known [32];
   bit           done      [32];
   int           alloc_edge [32];
   int           cmpl_cyc  [32];

   int      seed = 57800;
   int      cyc = 0;
   int      errors = 0;
   int      tests_run = 0;
   int      tests_failed = 0;
   int      next_rob = 0;
   int      next_reg = 16;
   t_rob_id mon_rob;
   t_prf_id pool [$];

   tb_clk_gen #(.PERIOD(20ns), .RESET_CYCLES(2)) clk_gen (.clk(clk), .reset(reset));

   rs_sched_top #(.RS_DEPTH(RS_DEPTH)) rs_sched_top_inst (.*);

   function automatic t_rv_reg_data alu_ref(t_alu_op op, t_rv_reg_data a, t_rv_reg_data b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         default: return a ^ b;
      endcase
   endfunction

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic fail_note(string what);
      $display("ERROR %s", what);
      errors++;
   endtask

   always @(posedge clk) cyc <= cyc + 1;

   // Completion checker, sampled mid-cycle where outputs are settled
   always @(negedge clk) begin
      if (!reset && cmpl_valid) begin
         mon_rob = cmpl_rob_id;
         assert (exp_known[mon_rob] && !done[mon_rob]) else begin
            $display("ERROR rob_id %0d completed without being expected or twice", mon_rob);
            errors++;
         end
         check_value("cmpl_data", cmpl_data, exp_data[mon_rob]);
         check_value("cmpl_pdst", cmpl_pdst, exp_pdst[mon_rob]);
         done[mon_rob]     = 1'b1;
         cmpl_cyc[mon_rob] = cyc;
         if (exp_known[mon_rob]) written[exp_pdst[mon_rob]] = 1'b1;
      end
   end

   task automatic step();
      @(posedge clk);
      #1;
      alloc     = 1'b0;
      ext_wr_en = 1'b0;
   endtask

   function automatic t_prf_id fresh_reg();
      next_reg++;
      return t_prf_id'(next_reg - 1);
   endfunction

   // Expected result is fixed at allocation from the model's planned values
   task automatic put_alloc(t_alu_op op, t_prf_id s1, t_prf_id s2, output int rob);
      t_prf_id d;
      d   = fresh_reg();
      rob = next_rob;
      next_rob++;
      alloc            = 1'b1;
      alloc_op         = op;
      alloc_psrc1      = s1;
      alloc_psrc1_pend = !written[s1];
      alloc_psrc2      = s2;
      alloc_psrc2_pend = !written[s2];
      alloc_pdst       = d;
      alloc_rob_id     = t_rob_id'(rob);
      model_val[d]     = alu_ref(op, model_val[s1], model_val[s2]);
      exp_data[rob]    = model_val[d];
      exp_pdst[rob]    = d;
      exp_known[rob]   = 1'b1;
      alloc_edge[rob]  = cyc + 1;
      pool.push_back(d);
   endtask

   task automatic put_ext(t_prf_id r);
      ext_wr_en   = 1'b1;
      ext_wr_pdst = r;
      ext_wr_data = model_val[r];
      written[r]  = 1'b1;
   endtask

   task automatic wait_done(int rob);
      int n;
      n = 0;
      while (!done[rob] && n < 60) begin
         step();
         n++;
      end
      assert (done[rob]) else fail_note($sformatf("rob_id %0d never completed", rob));
   endtask

   task automatic check_gap(string what, int got, int exp);
      assert (got == exp) else
         fail_note($sformatf("%s took %0d cycles instead of %0d", what, got, exp));
   endtask

   task automatic finish_test(string name, int err_before);
      tests_run++;
      if (errors != err_before) tests_failed++;
      $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   task automatic run_tests();
      int e0;
      int robs [8];
      t_prf_id r;
      int rob;

      // 1: independent micro-ops on preloaded registers
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         step();
         model_val[i] = $random(seed);
         put_ext(t_prf_id'(i));
         pool.push_back(t_prf_id'(i));
      end
      step();
      for (int i = 0; i < 4; i++) begin
         put_alloc(t_alu_op'(i), t_prf_id'(i), t_prf_id'(i + 4), robs[i]);
         step();
      end
      for (int i = 0; i < 4; i++) begin
         wait_done(robs[i]);
         check_gap("independent op", cmpl_cyc[robs[i]] - alloc_edge[robs[i]], 2);
      end
      finish_test("independent", e0);

      // 2: chain of dependent micro-ops
      e0 = errors;
      put_alloc(ALU_ADD, 8, 9, robs[0]);
      for (int i = 1; i < 4; i++) begin
         step();
         put_alloc(t_alu_op'(i), exp_pdst[robs[i-1]], t_prf_id'(10 + i), robs[i]);
      end
      step();
      for (int i = 0; i < 4; i++) wait_done(robs[i]);
      for (int i = 1; i < 4; i++) begin
         check_gap("dependent op", cmpl_cyc[robs[i]] - cmpl_cyc[robs[i-1]], 3);
      end
      finish_test("dependent chain", e0);

      // 3: pending source waits for its external write
      e0 = errors;
      r = fresh_reg();
      model_val[r] = $random(seed);
      put_alloc(ALU_SUB, r, 2, rob);
      repeat (6) step();
      assert (!done[rob]) else fail_note("op issued before its source was written");
      put_ext(r);
      pool.push_back(r);
      wait_done(rob);
      finish_test("pending external", e0);

      // 4: allocation in the same cycle as the matching write
      e0 = errors;
      step();
      r = fresh_reg();
      model_val[r] = $random(seed);
      put_alloc(ALU_XOR, 3, r, rob);
      put_ext(r);
      pool.push_back(r);
      wait_done(rob);
      check_gap("same-cycle wakeup", cmpl_cyc[rob] - alloc_edge[rob], 2);
      finish_test("same-cycle wakeup", e0);

      // 5: fill the station on one pending register, then drain it
      e0 = errors;
      step();
      r = fresh_reg();
      model_val[r] = $random(seed);
      for (int i = 0; i < RS_DEPTH; i++) begin
         put_alloc(t_alu_op'(i), r, t_prf_id'(i), robs[i]);
         step();
      end
      assert (rs_full) else fail_note("station not full after filling every entry");
      // A strobe while full is dropped, so rob_id 31 must never complete
      alloc            = 1'b1;
      alloc_op         = ALU_ADD;
      alloc_psrc1      = '0;
      alloc_psrc1_pend = 1'b0;
      alloc_psrc2      = '0;
      alloc_psrc2_pend = 1'b0;
      alloc_pdst       = '1;
      alloc_rob_id     = '1;
      put_ext(r);
      pool.push_back(r);
      for (int i = 0; i < RS_DEPTH; i++) wait_done(robs[i]);
      assert (!rs_full) else fail_note("station still full after draining");
      finish_test("full and drain", e0);

      // 6: random mix under rs_full flow control
      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         step();
         while (rs_full) step();
         put_alloc(t_alu_op'($random(seed)), pool[{$random(seed)} % pool.size()],
                   pool[{$random(seed)} % pool.size()], robs[i % 8]);
         if ({$random(seed)} % 3 == 0) begin
            r = fresh_reg();
            model_val[r] = $random(seed);
            put_ext(r);
            pool.push_back(r);
         end
      end
      step();
      for (int i = 0; i < next_rob; i++) wait_done(i);
      finish_test("random mix", e0);
   endtask

   initial begin
      alloc            = 1'b0;
      alloc_op         = ALU_ADD;
      alloc_psrc1      = '0;
      alloc_psrc1_pend = 1'b0;
      alloc_psrc2      = '0;
      alloc_psrc2_pend = 1'b0;
      alloc_pdst       = '0;
      alloc_rob_id     = '0;
      ext_wr_en        = 1'b0;
      ext_wr_pdst      = '0;
      ext_wr_data      = '0;
      @(negedge reset);
      run_tests();
      repeat (4) step();
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      #(TOTAL_CYCLES * 20ns + 1000ns);
      $display("ERROR run stopped by the watchdog after %0d cycles", cyc);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- dv/rs_sched_assert.sv
`timescale 1ns/1ps

module rs_sched_assert #(
   parameter int RS_DEPTH = 4
) (
   input logic                clk,
   input logic                reset,
   input logic                iss_valid,
   input logic                cmpl_valid,
   input logic [RS_DEPTH-1:0] e_valid,
   input logic [RS_DEPTH-1:0] e_ready,
   input logic [RS_DEPTH-1:0] dealloc,
   input logic [RS_DEPTH-1:0] e_alloc,
   input logic                alloc,
   input logic                rs_full
);

   logic [RS_DEPTH-1:0] cand;

   assign cand = e_valid & e_ready;

   // Execute is a single stage, so completion trails issue by one cycle
   a_cmpl_after_issue: assert property (@(posedge clk) disable iff (reset)
      iss_valid |=> cmpl_valid)
      else $error("completion did not follow an issue");

   a_cmpl_has_issue: assert property (@(posedge clk) disable iff (reset)
      cmpl_valid |-> $past(iss_valid))
      else $error("completion without an issue one cycle earlier");

   a_dealloc_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(dealloc))
      else $error("more than one entry deallocated in a cycle");

   // Isolating the lowest set candidate bit gives the entry that must be picked
   a_dealloc_lowest: assert property (@(posedge clk) disable iff (reset)
      dealloc == (cand & -cand))
      else $error("dealloc did not go to the lowest ready entry");

   a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
      (alloc && rs_full) |-> (e_alloc == '0))
      else $error("allocation accepted while the station was full");

endmodule

bind rs_sched_top rs_sched_assert #(
   .RS_DEPTH (RS_DEPTH)
) sched_assert (
   .clk        (clk),
   .reset      (reset),
   .iss_valid  (iss.valid),
   .cmpl_valid (cmpl_valid),
   .e_valid    (e_valid),
   .e_ready    (e_ready),
   .dealloc    (e_dealloc),
   .e_alloc    (e_alloc),
   .alloc      (alloc),
   .rs_full    (rs_full)
);

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter realtime PERIOD       = 20ns,
   parameter int      RESET_CYCLES = 2
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Released just after an edge so the first stimulus sees a clean start
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

//--- hdl/rs_sched_top.sv
`timescale 1ns/1ps

module rs_sched_top import rs_pkg::*; #(
   parameter int RS_DEPTH = 4
) (
   input  logic         clk,
   input  logic         reset,

   input  logic         alloc,
   input  t_alu_op      alloc_op,
   input  t_prf_id      alloc_psrc1,
   input  logic         alloc_psrc1_pend,
   input  t_prf_id      alloc_psrc2,
   input  logic         alloc_psrc2_pend,
   input  t_prf_id      alloc_pdst,
   input  t_rob_id      alloc_rob_id,

   input  logic         ext_wr_en,
   input  t_prf_id      ext_wr_pdst,
   input  t_rv_reg_data ext_wr_data,

   output logic         rs_full,
   output logic         cmpl_valid,
   output t_rob_id      cmpl_rob_id,
   output t_prf_id      cmpl_pdst,
   output t_rv_reg_data cmpl_data
);

   logic [RS_DEPTH-1:0] e_valid;
   logic [RS_DEPTH-1:0] e_ready;
   logic [RS_DEPTH-1:0] e_alloc;
   logic [RS_DEPTH-1:0] e_dealloc;
   t_alu_op             e_op     [RS_DEPTH-1:0];
   t_prf_id             e_psrc1  [RS_DEPTH-1:0];
   t_prf_id             e_psrc2  [RS_DEPTH-1:0];
   t_prf_id             e_pdst   [RS_DEPTH-1:0];
   t_rob_id             e_rob_id [RS_DEPTH-1:0];

   logic         iprf_wr_en   [IPRF_NUM_WRITES-1:0];
   t_prf_id      iprf_wr_pdst [IPRF_NUM_WRITES-1:0];
   t_rv_reg_data iprf_wr_data [IPRF_NUM_WRITES-1:0];

   logic         alu_wr_en;
   t_prf_id      alu_wr_pdst;
   t_rv_reg_data alu_wr_data;
   t_rv_reg_data rd_data1;
   t_rv_reg_data rd_data2;

   logic    free_any;
   t_rs_idx free_idx;

   rs_issue_if iss ();

   assign rs_full = &e_valid;

   // Lowest free slot takes the new micro-op, a strobe while full is dropped
   always_comb begin
      free_any = 1'b0;
      free_idx = '0;
      for (int i = RS_DEPTH-1; i >= 0; i--) begin
         if (!e_valid[i]) begin
            free_any = 1'b1;
            free_idx = t_rs_idx'(i);
         end
      end
      for (int i = 0; i < RS_DEPTH; i++) begin
         e_alloc[i] = alloc & free_any & (free_idx == t_rs_idx'(i));
      end
   end

   assign iprf_wr_en[0]   = alu_wr_en;
   assign iprf_wr_pdst[0] = alu_wr_pdst;
   assign iprf_wr_data[0] = alu_wr_data;
   assign iprf_wr_en[1]   = ext_wr_en;    // Stands in for load writeback
   assign iprf_wr_pdst[1] = ext_wr_pdst;
   assign iprf_wr_data[1] = ext_wr_data;

   for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
      rs_entry entry (
         .clk          (clk),
         .reset        (reset),
         .alloc        (e_alloc[i]),
         .op           (alloc_op),
         .psrc1        (alloc_psrc1),
         .psrc1_pend   (alloc_psrc1_pend),
         .psrc2        (alloc_psrc2),
         .psrc2_pend   (alloc_psrc2_pend),
         .pdst         (alloc_pdst),
         .rob_id       (alloc_rob_id),
         .iprf_wr_en   (iprf_wr_en),
         .iprf_wr_pdst (iprf_wr_pdst),
         .dealloc      (e_dealloc[i]),
         .valid        (e_valid[i]),
         .ready        (e_ready[i]),
         .e_op         (e_op[i]),
         .e_psrc1      (e_psrc1[i]),
         .e_psrc2      (e_psrc2[i]),
         .e_pdst       (e_pdst[i]),
         .e_rob_id     (e_rob_id[i])
      );
   end

   rs_pick #(
      .RS_DEPTH (RS_DEPTH)
   ) pick (
      .clk      (clk),
      .reset    (reset),
      .valid    (e_valid),
      .ready    (e_ready),
      .e_op     (e_op),
      .e_psrc1  (e_psrc1),
      .e_psrc2  (e_psrc2),
      .e_pdst   (e_pdst),
      .e_rob_id (e_rob_id),
      .dealloc  (e_dealloc),
      .iss      (iss.src)
   );

   prf_file prf (
      .clk          (clk),
      .iprf_wr_en   (iprf_wr_en),
      .iprf_wr_pdst (iprf_wr_pdst),
      .iprf_wr_data (iprf_wr_data),
      .rd_id1       (iss.psrc1),
      .rd_id2       (iss.psrc2),
      .rd_data1     (rd_data1),
      .rd_data2     (rd_data2)
   );

   exec_alu alu (
      .clk         (clk),
      .reset       (reset),
      .iss         (iss.dst),
      .rd_data1    (rd_data1),
      .rd_data2    (rd_data2),
      .wr_en       (alu_wr_en),
      .wr_pdst     (alu_wr_pdst),
      .wr_data     (alu_wr_data),
      .cmpl_valid  (cmpl_valid),
      .cmpl_rob_id (cmpl_rob_id),
      .cmpl_pdst   (cmpl_pdst),
      .cmpl_data   (cmpl_data)
   );

endmodule

//--- hdl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import rs_pkg::*; (
   input  logic         clk,
   input  logic         reset,

   rs_issue_if.dst      iss,
   input  t_rv_reg_data rd_data1,
   input  t_rv_reg_data rd_data2,

   output logic         wr_en,
   output t_prf_id      wr_pdst,
   output t_rv_reg_data wr_data,

   output logic         cmpl_valid,
   output t_rob_id      cmpl_rob_id,
   output t_prf_id      cmpl_pdst,
   output t_rv_reg_data cmpl_data
);

   t_rv_reg_data alu_res;
   logic         res_valid;
   t_prf_id      res_pdst;
   t_rob_id      res_rob_id;
   t_rv_reg_data res_data;

   always_comb begin
      unique case (iss.op)
         ALU_ADD: alu_res = rd_data1 + rd_data2;
         ALU_SUB: alu_res = rd_data1 - rd_data2;
         ALU_AND: alu_res = rd_data1 & rd_data2;
         ALU_XOR: alu_res = rd_data1 ^ rd_data2;
         default: alu_res = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) res_valid <= 1'b0;
      else res_valid <= iss.valid;
   end

   always_ff @(posedge clk) begin
      if (iss.valid) begin
         res_pdst   <= iss.pdst;
         res_rob_id <= iss.rob_id;
         res_data   <= alu_res;
      end
   end

   // The same registered result feeds write port 0 and the completion report
   assign wr_en       = res_valid;
   assign wr_pdst     = res_pdst;
   assign wr_data     = res_data;

   assign cmpl_valid  = res_valid;
   assign cmpl_rob_id = res_rob_id;
   assign cmpl_pdst   = res_pdst;
   assign cmpl_data   = res_data;

endmodule

//--- hdl/prf_file.sv
`timescale 1ns/1ps

module prf_file import rs_pkg::*; (
   input  logic         clk,

   input  logic         iprf_wr_en   [IPRF_NUM_WRITES-1:0],
   input  t_prf_id      iprf_wr_pdst [IPRF_NUM_WRITES-1:0],
   input  t_rv_reg_data iprf_wr_data [IPRF_NUM_WRITES-1:0],

   input  t_prf_id      rd_id1,
   input  t_prf_id      rd_id2,
   output t_rv_reg_data rd_data1,
   output t_rv_reg_data rd_data2
);

   t_rv_reg_data regs [PRF_ENTRIES];

   // Highest port is applied first, so port 0 lands last and wins a collision
   always_ff @(posedge clk) begin
      for (int p = IPRF_NUM_WRITES-1; p >= 0; p--) begin
         if (iprf_wr_en[p]) begin
            regs[iprf_wr_pdst[p]] <= iprf_wr_data[p];
         end
      end
   end

   assign rd_data1 = regs[rd_id1];  // Asynchronous read during the issue cycle
   assign rd_data2 = regs[rd_id2];

endmodule

//--- hdl/rs_pick.sv
`timescale 1ns/1ps

module rs_pick import rs_pkg::*; #(
   parameter int RS_DEPTH = 4
) (
   input  logic              clk,
   input  logic              reset,

   input  logic [RS_DEPTH-1:0] valid,
   input  logic [RS_DEPTH-1:0] ready,
   input  t_alu_op           e_op     [RS_DEPTH-1:0],
   input  t_prf_id           e_psrc1  [RS_DEPTH-1:0],
   input  t_prf_id           e_psrc2  [RS_DEPTH-1:0],
   input  t_prf_id           e_pdst   [RS_DEPTH-1:0],
   input  t_rob_id           e_rob_id [RS_DEPTH-1:0],

   output logic [RS_DEPTH-1:0] dealloc,
   rs_issue_if.src           iss
);

   logic    pick_any;
   t_rs_idx sel_idx;
   t_alu_op sel_op;
   t_prf_id sel_psrc1;
   t_prf_id sel_psrc2;
   t_prf_id sel_pdst;
   t_rob_id sel_rob_id;

   // Walk from the top so the lowest ready index is the last one kept
   always_comb begin
      pick_any   = 1'b0;
      sel_idx    = '0;
      sel_op     = e_op[0];
      sel_psrc1  = e_psrc1[0];
      sel_psrc2  = e_psrc2[0];
      sel_pdst   = e_pdst[0];
      sel_rob_id = e_rob_id[0];
      for (int i = RS_DEPTH-1; i >= 0; i--) begin
         if (valid[i] & ready[i]) begin
            pick_any   = 1'b1;
            sel_idx    = t_rs_idx'(i);
            sel_op     = e_op[i];
            sel_psrc1  = e_psrc1[i];
            sel_psrc2  = e_psrc2[i];
            sel_pdst   = e_pdst[i];
            sel_rob_id = e_rob_id[i];
         end
      end
   end

   always_comb begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         dealloc[i] = pick_any & (sel_idx == t_rs_idx'(i));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) iss.valid <= 1'b0;
      else iss.valid <= pick_any;
   end

   always_ff @(posedge clk) begin
      iss.op     <= sel_op;
      iss.psrc1  <= sel_psrc1;
      iss.psrc2  <= sel_psrc2;
      iss.pdst   <= sel_pdst;
      iss.rob_id <= sel_rob_id;
   end

endmodule

//--- hdl/rs_entry.sv
`timescale 1ns/1ps

module rs_entry import rs_pkg::*; (
   input  logic    clk,
   input  logic    reset,

   input  logic    alloc,
   input  t_alu_op op,
   input  t_prf_id psrc1,
   input  logic    psrc1_pend,
   input  t_prf_id psrc2,
   input  logic    psrc2_pend,
   input  t_prf_id pdst,
   input  t_rob_id rob_id,

   input  logic    iprf_wr_en   [IPRF_NUM_WRITES-1:0],
   input  t_prf_id iprf_wr_pdst [IPRF_NUM_WRITES-1:0],

   input  logic    dealloc,

   output logic    valid,
   output logic    ready,
   output t_alu_op e_op,
   output t_prf_id e_psrc1,
   output t_prf_id e_psrc2,
   output t_prf_id e_pdst,
   output t_rob_id e_rob_id
);

   logic src1_ready;
   logic src2_ready;

   always_ff @(posedge clk) begin
      if (reset) valid <= 1'b0;
      else if (alloc) valid <= 1'b1;
      else if (dealloc) valid <= 1'b0;
   end

   // Static payload of the micro-op, captured once per allocation
   always_ff @(posedge clk) begin
      if (alloc) begin
         e_op     <= op;
         e_psrc1  <= psrc1;
         e_psrc2  <= psrc2;
         e_pdst   <= pdst;
         e_rob_id <= rob_id;
      end
   end

   rs_reg_trk src1_trk (
      .clk              (clk),
      .reset            (reset),
      .e_alloc_rs0      (alloc),
      .psrc             (psrc1),
      .psrc_pend        (psrc1_pend),
      .e_dealloc        (dealloc),
      .iprf_wr_en_ro0   (iprf_wr_en),
      .iprf_wr_pdst_ro0 (iprf_wr_pdst),
      .ready_rs1        (src1_ready)
   );

   rs_reg_trk src2_trk (
      .clk              (clk),
      .reset            (reset),
      .e_alloc_rs0      (alloc),
      .psrc             (psrc2),
      .psrc_pend        (psrc2_pend),
      .e_dealloc        (dealloc),
      .iprf_wr_en_ro0   (iprf_wr_en),
      .iprf_wr_pdst_ro0 (iprf_wr_pdst),
      .ready_rs1        (src2_ready)
   );

   assign ready = src1_ready & src2_ready;

endmodule

//--- hdl/rs_reg_trk.sv
`timescale 1ns/1ps

module rs_reg_trk import rs_pkg::*; (
   input  logic    clk,
   input  logic    reset,

   input  logic    e_alloc_rs0,
   input  t_prf_id psrc,
   input  logic    psrc_pend,
   input  logic    e_dealloc,

   input  logic    iprf_wr_en_ro0   [IPRF_NUM_WRITES-1:0],
   input  t_prf_id iprf_wr_pdst_ro0 [IPRF_NUM_WRITES-1:0],

   output logic    ready_rs1
);

   typedef enum logic [1:0] {
      SRC_IDLE,
      SRC_PDG_RSLT,
      SRC_READY
   } t_fsm;

   t_fsm    fsm;
   t_fsm    fsm_nxt;
   t_prf_id psrc_q;
   t_prf_id psrc_cmp;
   logic    wr_match_any;

   // On the allocation cycle the incoming id is compared, later the stored one
   assign psrc_cmp = e_alloc_rs0 ? psrc : psrc_q;

   always_ff @(posedge clk) begin
      if (e_alloc_rs0) begin
         psrc_q <= psrc;
      end
   end

   always_comb begin
      wr_match_any = 1'b0;
      for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
         wr_match_any |= iprf_wr_en_ro0[p] & (iprf_wr_pdst_ro0[p] == psrc_cmp);
      end
   end

   always_comb begin
      fsm_nxt = fsm;
      unique case (fsm)
         SRC_IDLE: begin
            if (e_alloc_rs0) begin
               fsm_nxt = (~psrc_pend | wr_match_any) ? SRC_READY : SRC_PDG_RSLT;
            end
         end
         SRC_PDG_RSLT: begin
            if (wr_match_any) fsm_nxt = SRC_READY;
            else if (e_dealloc) fsm_nxt = SRC_IDLE;
         end
         SRC_READY: begin
            if (e_dealloc) fsm_nxt = SRC_IDLE;
         end
         default: fsm_nxt = SRC_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) fsm <= SRC_IDLE;
      else fsm <= fsm_nxt;
   end

   assign ready_rs1 = (fsm == SRC_READY);

endmodule

//--- hdl/rs_issue_if.sv
`timescale 1ns/1ps

// One issued micro-op on its way from the pick stage to execute
interface rs_issue_if import rs_pkg::*; ();

   logic    valid;
   t_alu_op op;
   t_prf_id psrc1;
   t_prf_id psrc2;
   t_prf_id pdst;
   t_rob_id rob_id;

   modport src (
      output valid,
      output op,
      output psrc1,
      output psrc2,
      output pdst,
      output rob_id
   );

   modport dst (
      input valid,
      input op,
      input psrc1,
      input psrc2,
      input pdst,
      input rob_id
   );

endinterface

//--- hdl/rs_pkg.sv
package rs_pkg;

   // Physical register file geometry
   localparam int PRF_ENTRIES = 64;
   localparam int PRF_ID_W    = $clog2(PRF_ENTRIES);
   localparam int XLEN        = 32;

   // Port 0 is the local ALU result and port 1 is the external (load) write
   localparam int IPRF_NUM_WRITES = 2;

   localparam int ROB_ID_W = 5;
   localparam int ALU_OP_W = 2;

   // Wide enough for a station of up to 8 entries
   localparam int RS_IDX_W = 3;

   typedef logic [PRF_ID_W-1:0] t_prf_id;
   typedef logic [XLEN-1:0]     t_rv_reg_data;
   typedef logic [ROB_ID_W-1:0] t_rob_id;
   typedef logic [ALU_OP_W-1:0] t_alu_op;
   typedef logic [RS_IDX_W-1:0] t_rs_idx;

   localparam t_alu_op ALU_ADD = 2'd0;
   localparam t_alu_op ALU_SUB = 2'd1;
   localparam t_alu_op ALU_AND = 2'd2;
   localparam t_alu_op ALU_XOR = 2'd3;

endpackage
